/* dcache.sv */
`timescale 1ns/1ps

module dcache (
    input  logic                      clock,
    input  logic                      reset,

    input  logic                      req_valid,
    input  logic                      req_ready,
    input  dcache_pkg::addr_t         req_addr,
    input  dcache_pkg::data_t         req_data,
    input  dcache_pkg::mem_size_e     req_size,
    input  logic                      req_is_store,

    input  dcache_pkg::mem_command_e  mshr_command,
    input  logic                      fill_wr,
    input  dcache_pkg::addr_t         fill_addr,
    input  dcache_pkg::mem_block_t    fill_block,
    input  dcache_pkg::data_t         fill_data,
    input  dcache_pkg::mem_size_e     fill_size,
    input  logic                      fill_is_store,
    input  logic                      fill_is_load,

    output logic                      hit,
    output logic                      resp_valid,
    output dcache_pkg::data_t         resp_data,

    output dcache_pkg::mem_command_e  proc2mem_command,
    output dcache_pkg::addr_t         proc2mem_addr,
    output dcache_pkg::mem_block_t    proc2mem_data
);

    logic [dcache_pkg::LINES-1:0] valid_bits;
    dcache_pkg::cache_tag_t       tags  [dcache_pkg::LINES];
    dcache_pkg::mem_block_t       lines [dcache_pkg::LINES];

    logic [dcache_pkg::INDEX_BITS-1:0]  req_index;
    logic [dcache_pkg::OFFSET_BITS-1:0] req_offset;
    dcache_pkg::cache_tag_t             req_tag;
    logic [dcache_pkg::INDEX_BITS-1:0]  fill_index;
    logic [dcache_pkg::OFFSET_BITS-1:0] fill_offset;
    dcache_pkg::cache_tag_t             fill_tag;

    logic                   accepted;
    logic                   store_hit;
    dcache_pkg::mem_block_t store_block;
    dcache_pkg::mem_block_t fill_merged;

    // Shift the addressed bytes down and zero-extend to a word
    function automatic dcache_pkg::data_t extract_load(
        input dcache_pkg::mem_block_t              block,
        input logic [dcache_pkg::OFFSET_BITS-1:0]  offset,
        input dcache_pkg::mem_size_e               size
    );
        dcache_pkg::mem_block_t shifted;
        shifted = block >> {offset, 3'b000};
        case (size)
            dcache_pkg::BYTE: return {24'h0, shifted[7:0]};
            dcache_pkg::HALF: return {16'h0, shifted[15:0]};
            default:          return shifted[31:0];
        endcase
    endfunction

    function automatic dcache_pkg::mem_block_t merge_store(
        input dcache_pkg::mem_block_t              block,
        input logic [dcache_pkg::OFFSET_BITS-1:0]  offset,
        input dcache_pkg::mem_size_e               size,
        input dcache_pkg::data_t                   data
    );
        dcache_pkg::mem_block_t merged;
        merged = block;
        case (size)
            dcache_pkg::BYTE: merged[{offset, 3'b000} +: 8]  = data[7:0];
            dcache_pkg::HALF: merged[{offset, 3'b000} +: 16] = data[15:0];
            default:          merged[{offset, 3'b000} +: 32] = data;
        endcase
        return merged;
    endfunction

    assign req_offset  = req_addr[dcache_pkg::OFFSET_BITS-1:0];
    assign req_index   = req_addr[dcache_pkg::OFFSET_BITS +: dcache_pkg::INDEX_BITS];
    assign req_tag     = req_addr[$bits(dcache_pkg::addr_t)-1 -: dcache_pkg::TAG_BITS];
    assign fill_offset = fill_addr[dcache_pkg::OFFSET_BITS-1:0];
    assign fill_index  = fill_addr[dcache_pkg::OFFSET_BITS +: dcache_pkg::INDEX_BITS];
    assign fill_tag    = fill_addr[$bits(dcache_pkg::addr_t)-1 -: dcache_pkg::TAG_BITS];

    assign hit       = valid_bits[req_index] && (tags[req_index] == req_tag);
    assign accepted  = req_valid && req_ready;
    assign store_hit = accepted && hit && req_is_store;

    assign store_block = merge_store(lines[req_index], req_offset, req_size, req_data);
    assign fill_merged = fill_is_store ?
                         merge_store(fill_block, fill_offset, fill_size, fill_data) : fill_block;

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_bits <= '0;
        end else if (fill_wr) begin
            valid_bits[fill_index] <= 1'b1;
        end
    end

    // No request is accepted while a fill is presented
    always_ff @(posedge clock) begin
        if (fill_wr) begin
            tags[fill_index]  <= fill_tag;
            lines[fill_index] <= fill_merged;
        end else if (store_hit) begin
            lines[req_index] <= store_block;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= (accepted && hit && !req_is_store) || fill_is_load;
        end
    end

    always_ff @(posedge clock) begin
        if (accepted && hit && !req_is_store) begin
            resp_data <= extract_load(lines[req_index], req_offset, req_size);
        end else if (fill_is_load) begin
            resp_data <= extract_load(fill_block, fill_offset, fill_size);
        end
    end

    always_comb begin
        proc2mem_command = mshr_command;
        proc2mem_addr    = {req_addr[$bits(dcache_pkg::addr_t)-1:dcache_pkg::OFFSET_BITS],
                            {dcache_pkg::OFFSET_BITS{1'b0}}};
        proc2mem_data    = '0;
        if (fill_wr) begin
            proc2mem_addr = {fill_addr[$bits(dcache_pkg::addr_t)-1:dcache_pkg::OFFSET_BITS],
                             {dcache_pkg::OFFSET_BITS{1'b0}}};
            proc2mem_data = fill_merged;
        end else if (store_hit) begin
            proc2mem_command = dcache_pkg::MEM_STORE;
            proc2mem_data    = store_block;
        end
    end

endmodule

/* dcache_pkg.sv */
package dcache_pkg;

    // Processor side and memory side widths
    typedef logic [15:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [63:0] mem_block_t;

    // Zero is reserved to mean no transaction
    typedef logic [3:0] mem_tag_t;

    typedef enum logic [1:0] {
        BYTE = 2'h0,
        HALF = 2'h1,
        WORD = 2'h2
    } mem_size_e;

    typedef enum logic [1:0] {
        MEM_NONE  = 2'h0,
        MEM_LOAD  = 2'h1,
        MEM_STORE = 2'h2
    } mem_command_e;

    typedef enum logic [1:0] {
        NONE                  = 2'h0,
        WAITING_FOR_LOAD_DATA = 2'h1,
        TRANSACTION_COMPLETE  = 2'h2
    } mshr_state_e;

    // Direct-mapped geometry, one 8-byte block per line
    localparam int LINES       = 16;
    localparam int OFFSET_BITS = 3;
    localparam int INDEX_BITS  = 4;
    localparam int TAG_BITS    = $bits(addr_t) - INDEX_BITS - OFFSET_BITS;

    typedef logic [TAG_BITS-1:0] cache_tag_t;

endpackage

/* dcache_top.f */
dcache_pkg.sv
mshr.sv
dcache.sv
dcache_top.sv
tb_clock_gen.sv
tb_checker.sv
tb_dcache_top.sv

/* dcache_top.sv */
`timescale 1ns/1ps

module dcache_top (
    input  logic                      clock,
    input  logic                      reset,

    input  logic                      req_valid,
    input  dcache_pkg::addr_t         req_addr,
    input  dcache_pkg::data_t         req_data,
    input  dcache_pkg::mem_size_e     req_size,
    input  logic                      req_is_store,
    output logic                      req_ready,

    output logic                      resp_valid,
    output dcache_pkg::data_t         resp_data,

    input  dcache_pkg::mem_tag_t      mem2proc_transaction_tag,
    input  dcache_pkg::mem_tag_t      mem2proc_data_tag,
    input  dcache_pkg::mem_block_t    mem2proc_data,
    output dcache_pkg::mem_command_e  proc2mem_command,
    output dcache_pkg::addr_t         proc2mem_addr,
    output dcache_pkg::mem_block_t    proc2mem_data
);

    logic                      hit;
    logic                      stall;
    dcache_pkg::mem_command_e  mshr_command;
    logic                      fill_wr;
    dcache_pkg::addr_t         fill_addr;
    dcache_pkg::mem_block_t    fill_block;
    dcache_pkg::data_t         fill_data;
    dcache_pkg::mem_size_e     fill_size;
    logic                      fill_is_store;
    logic                      fill_is_load;

    // Requests wait for as long as a miss is outstanding
    assign req_ready = ~stall;

    mshr u_mshr (
        .clock                    (clock),
        .reset                    (reset),
        .valid                    (req_valid),
        .in_addr                  (req_addr),
        .in_data                  (req_data),
        .st_size                  (req_size),
        .is_store                 (req_is_store),
        .hit                      (hit),
        .mem2proc_transaction_tag (mem2proc_transaction_tag),
        .mem2proc_data_tag        (mem2proc_data_tag),
        .mem2proc_data            (mem2proc_data),
        .mshr_command             (mshr_command),
        .fill_wr                  (fill_wr),
        .fill_addr                (fill_addr),
        .fill_block               (fill_block),
        .fill_data                (fill_data),
        .fill_size                (fill_size),
        .fill_is_store            (fill_is_store),
        .fill_is_load             (fill_is_load),
        .stall                    (stall)
    );

    dcache u_dcache (
        .clock            (clock),
        .reset            (reset),
        .req_valid        (req_valid),
        .req_ready        (req_ready),
        .req_addr         (req_addr),
        .req_data         (req_data),
        .req_size         (req_size),
        .req_is_store     (req_is_store),
        .mshr_command     (mshr_command),
        .fill_wr          (fill_wr),
        .fill_addr        (fill_addr),
        .fill_block       (fill_block),
        .fill_data        (fill_data),
        .fill_size        (fill_size),
        .fill_is_store    (fill_is_store),
        .fill_is_load     (fill_is_load),
        .hit              (hit),
        .resp_valid       (resp_valid),
        .resp_data        (resp_data),
        .proc2mem_command (proc2mem_command),
        .proc2mem_addr    (proc2mem_addr),
        .proc2mem_data    (proc2mem_data)
    );

endmodule

/* mshr.sv */
`timescale 1ns/1ps

module mshr (
    input  logic                      clock,
    input  logic                      reset,

    input  logic                      valid,
    input  dcache_pkg::addr_t         in_addr,
    input  dcache_pkg::data_t         in_data,
    input  dcache_pkg::mem_size_e     st_size,
    input  logic                      is_store,

    input  logic                      hit,

    input  dcache_pkg::mem_tag_t      mem2proc_transaction_tag,
    input  dcache_pkg::mem_tag_t      mem2proc_data_tag,
    input  dcache_pkg::mem_block_t    mem2proc_data,

    output dcache_pkg::mem_command_e  mshr_command,

    output logic                      fill_wr,
    output dcache_pkg::addr_t         fill_addr,
    output dcache_pkg::mem_block_t    fill_block,
    output dcache_pkg::data_t         fill_data,
    output dcache_pkg::mem_size_e     fill_size,
    output logic                      fill_is_store,
    output logic                      fill_is_load,

    output logic                      stall
);

    dcache_pkg::mshr_state_e  state;
    dcache_pkg::mshr_state_e  next_state;
    dcache_pkg::mem_tag_t     mem_tag;

    // Saved copy of the missing request
    dcache_pkg::addr_t        miss_addr;
    dcache_pkg::data_t        miss_data;
    dcache_pkg::mem_size_e    miss_size;
    logic                     miss_is_store;
    dcache_pkg::mem_block_t   miss_block;

    logic start_miss;
    logic data_match;

    // Only one miss can be in flight, so new requests wait
    assign stall = (state != dcache_pkg::NONE);

    assign start_miss = (state == dcache_pkg::NONE) && valid && !hit;
    assign data_match = (state == dcache_pkg::WAITING_FOR_LOAD_DATA) &&
                        (mem_tag != '0) && (mem2proc_data_tag == mem_tag);

    always_comb begin
        next_state = state;
        case (state)
            dcache_pkg::NONE: begin
                if (start_miss) begin
                    next_state = dcache_pkg::WAITING_FOR_LOAD_DATA;
                end
            end
            dcache_pkg::WAITING_FOR_LOAD_DATA: begin
                if (data_match) begin
                    next_state = dcache_pkg::TRANSACTION_COMPLETE;
                end
            end
            default: begin
                next_state = dcache_pkg::NONE;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state   <= dcache_pkg::NONE;
            mem_tag <= '0;
        end else begin
            state <= next_state;
            if (start_miss) begin
                mem_tag <= mem2proc_transaction_tag;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (start_miss) begin
            miss_addr     <= in_addr;
            miss_data     <= in_data;
            miss_size     <= st_size;
            miss_is_store <= is_store;
        end
        if (data_match) begin
            miss_block <= mem2proc_data;
        end
    end

    // Store misses write the merged block through while the fill is presented
    always_comb begin
        mshr_command = dcache_pkg::MEM_NONE;
        if (start_miss) begin
            mshr_command = dcache_pkg::MEM_LOAD;
        end else if (fill_wr && miss_is_store) begin
            mshr_command = dcache_pkg::MEM_STORE;
        end
    end

    assign fill_wr       = (state == dcache_pkg::TRANSACTION_COMPLETE);
    assign fill_addr     = miss_addr;
    assign fill_block    = miss_block;
    assign fill_data     = miss_data;
    assign fill_size     = miss_size;
    assign fill_is_store = fill_wr && miss_is_store;
    assign fill_is_load  = fill_wr && !miss_is_store;

endmodule

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module tb_dcache_top -f dcache_top.f &&
output=$(./obj_dir/Vtb_dcache_top) &&
echo "$output" &&
echo "$output" | grep -q "all tests passed" ||
{ echo "simulation did not pass"; exit 1; }

/* tb_checker.sv */
`timescale 1ns/1ps

module tb_checker (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      req_valid,
    input  logic                      req_ready,
    input  dcache_pkg::addr_t         req_addr,
    input  dcache_pkg::data_t         req_data,
    input  dcache_pkg::mem_size_e     req_size,
    input  logic                      req_is_store,
    input  logic                      resp_valid,
    input  dcache_pkg::data_t         resp_data,
    input  dcache_pkg::mem_command_e  proc2mem_command,
    input  dcache_pkg::addr_t         proc2mem_addr,
    input  dcache_pkg::mem_block_t    proc2mem_data,
    output int                        error_count,
    output int                        loads_pending,
    output logic                      miss_pending
);

    string             current_test = "reset";
    logic [7:0]        ref_mem [512];
    dcache_pkg::data_t expected_loads [$];
    int                errors = 0;
    int                queued = 0;
    logic              miss_open = 1'b0;

    assign error_count   = errors;
    assign loads_pending = queued;
    assign miss_pending  = miss_open;

    function automatic int size_bytes(input dcache_pkg::mem_size_e size);
        case (size)
            dcache_pkg::BYTE: return 1;
            dcache_pkg::HALF: return 2;
            default:          return 4;
        endcase
    endfunction

    // Little-endian gather, zero-extended
    function automatic dcache_pkg::data_t model_load(
        input dcache_pkg::addr_t     addr,
        input dcache_pkg::mem_size_e size
    );
        dcache_pkg::data_t value;
        value = '0;
        for (int k = 0; k < size_bytes(size); k++) begin
            value[8*k +: 8] = ref_mem[addr[8:0] + 9'(k)];
        end
        return value;
    endfunction

    function automatic dcache_pkg::mem_block_t model_block(input dcache_pkg::addr_t addr);
        dcache_pkg::mem_block_t block;
        for (int k = 0; k < 8; k++) begin
            block[8*k +: 8] = ref_mem[{addr[8:3], 3'(k)}];
        end
        return block;
    endfunction

    initial begin
        for (int i = 0; i < 512; i++) begin
            ref_mem[i] = (8'(i) + 8'h5A) ^ ((i >= 256) ? 8'h80 : 8'h00);
        end
    end

    always @(posedge clock) begin
        dcache_pkg::data_t      expected;
        dcache_pkg::mem_block_t block;
        if (reset) begin
            miss_open = 1'b0;
        end else begin
            if (resp_valid) begin
                if (expected_loads.size() == 0) begin
                    $display("%s: a response arrived with no load outstanding", current_test);
                    errors++;
                end else begin
                    expected = expected_loads.pop_front();
                    if (resp_data !== expected) begin
                        $display("ERROR %s: load response expected 0x%08h actual 0x%08h",
                                 current_test, expected, resp_data);
                        errors++;
                    end
                end
            end
            if (req_valid && req_ready) begin
                if (req_is_store) begin
                    for (int k = 0; k < size_bytes(req_size); k++) begin
                        ref_mem[req_addr[8:0] + 9'(k)] = req_data[8*k +: 8];
                    end
                    // Stores either write through at once or start a miss
                    if (proc2mem_command == dcache_pkg::MEM_NONE) begin
                        $display("%s: store to 0x%04h was accepted with no memory command",
                                 current_test, req_addr);
                        errors++;
                    end
                end else begin
                    expected_loads.push_back(model_load(req_addr, req_size));
                end
            end
            // Store misses reach here in the fill cycle, after the model took the store
            if (proc2mem_command == dcache_pkg::MEM_STORE) begin
                block = model_block(proc2mem_addr);
                if (proc2mem_data !== block) begin
                    $display("ERROR %s: store block at 0x%04h expected 0x%016h actual 0x%016h",
                             current_test, proc2mem_addr, block, proc2mem_data);
                    errors++;
                end
            end
            if (miss_open && req_ready && !resp_valid) begin
                $display("%s: req_ready was high while a miss was outstanding", current_test);
                errors++;
            end
            if (resp_valid || proc2mem_command == dcache_pkg::MEM_STORE) begin
                miss_open = 1'b0;
            end
            if (proc2mem_command == dcache_pkg::MEM_LOAD) begin
                miss_open = 1'b1;
            end
            queued = expected_loads.size();
        end
    end

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clock
);

    // 4 ns period
    initial begin
        clock = 1'b0;
        forever begin
            #2 clock = ~clock;
        end
    end

endmodule

/* tb_dcache_top.sv */
`timescale 1ns/1ps

module tb_dcache_top;

    localparam int WAIT_LIMIT = 100;

    logic                      clock;
    logic                      reset;
    logic                      req_valid;
    dcache_pkg::addr_t         req_addr;
    dcache_pkg::data_t         req_data;
    dcache_pkg::mem_size_e     req_size;
    logic                      req_is_store;
    logic                      req_ready;
    logic                      resp_valid;
    dcache_pkg::data_t         resp_data;
    dcache_pkg::mem_tag_t      mem2proc_transaction_tag;
    dcache_pkg::mem_tag_t      mem2proc_data_tag = '0;
    dcache_pkg::mem_block_t    mem2proc_data = '0;
    dcache_pkg::mem_command_e  proc2mem_command;
    dcache_pkg::addr_t         proc2mem_addr;
    dcache_pkg::mem_block_t    proc2mem_data;
    int                        checker_errors;
    int                        loads_pending;
    logic                      miss_pending;

    // Memory model, 512 bytes as 64 blocks
    dcache_pkg::mem_block_t    mem_blocks [64];
    dcache_pkg::mem_tag_t      next_tag = 4'd1;
    dcache_pkg::mem_tag_t      pend_tag = '0;
    logic [5:0]                pend_block = '0;
    int                        pend_count = 0;
    dcache_pkg::mem_tag_t      ret_tag = '0;
    dcache_pkg::mem_block_t    ret_data = '0;

    string current_test = "reset";
    int    tb_errors = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    int    errors_before = 0;
    logic  timed_out = 1'b0;

    tb_clock_gen u_clock_gen (
        .clock (clock)
    );

    dcache_top u_dcache_top (
        .clock                    (clock),
        .reset                    (reset),
        .req_valid                (req_valid),
        .req_addr                 (req_addr),
        .req_data                 (req_data),
        .req_size                 (req_size),
        .req_is_store             (req_is_store),
        .req_ready                (req_ready),
        .resp_valid               (resp_valid),
        .resp_data                (resp_data),
        .mem2proc_transaction_tag (mem2proc_transaction_tag),
        .mem2proc_data_tag        (mem2proc_data_tag),
        .mem2proc_data            (mem2proc_data),
        .proc2mem_command         (proc2mem_command),
        .proc2mem_addr            (proc2mem_addr),
        .proc2mem_data            (proc2mem_data)
    );

    tb_checker u_checker (
        .clock            (clock),
        .reset            (reset),
        .req_valid        (req_valid),
        .req_ready        (req_ready),
        .req_addr         (req_addr),
        .req_data         (req_data),
        .req_size         (req_size),
        .req_is_store     (req_is_store),
        .resp_valid       (resp_valid),
        .resp_data        (resp_data),
        .proc2mem_command (proc2mem_command),
        .proc2mem_addr    (proc2mem_addr),
        .proc2mem_data    (proc2mem_data),
        .error_count      (checker_errors),
        .loads_pending    (loads_pending),
        .miss_pending     (miss_pending)
    );

    // Memory accepts a load in the same cycle and hands back a rotating nonzero tag
    assign mem2proc_transaction_tag =
        (proc2mem_command == dcache_pkg::MEM_LOAD) ? next_tag : 4'd0;

    always @(posedge clock) begin
        ret_tag = '0;
        if (pend_count == 1) begin
            ret_tag  = pend_tag;
            ret_data = mem_blocks[pend_block];
        end
        if (pend_count > 0) begin
            pend_count = pend_count - 1;
        end
        if (proc2mem_command == dcache_pkg::MEM_LOAD) begin
            pend_tag   = mem2proc_transaction_tag;
            pend_block = proc2mem_addr[8:3];
            pend_count = $urandom_range(2, 9);
            next_tag  <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
        end else if (proc2mem_command == dcache_pkg::MEM_STORE) begin
            mem_blocks[proc2mem_addr[8:3]] = proc2mem_data;
        end
    end

    always @(negedge clock) begin
        mem2proc_data_tag = ret_tag;
        mem2proc_data     = ret_data;
    end

    task automatic issue(
        input dcache_pkg::addr_t     addr,
        input dcache_pkg::data_t     data,
        input dcache_pkg::mem_size_e size,
        input logic                  is_store
    );
        int waited;
        waited = 0;
        if (!timed_out) begin
            @(negedge clock);
            req_valid    = 1'b1;
            req_addr     = addr;
            req_data     = data;
            req_size     = size;
            req_is_store = is_store;
            // req_ready only moves at the rising edge
            while (!req_ready && waited < WAIT_LIMIT) begin
                @(negedge clock);
                waited++;
            end
            if (!req_ready) begin
                $display("%s: request to 0x%04h was not accepted within %0d cycles",
                         current_test, addr, WAIT_LIMIT);
                timed_out = 1'b1;
                req_valid = 1'b0;
            end else begin
                @(posedge clock);
            end
        end
    endtask

    task automatic idle_cycle();
        if (!timed_out) begin
            @(negedge clock);
            req_valid = 1'b0;
        end
    endtask

    task automatic check_hit_latency();
        if (!timed_out) begin
            @(negedge clock);
            req_valid = 1'b0;
            if (resp_valid !== 1'b1) begin
                $display("ERROR %s: resp_valid one cycle after acceptance expected 1 actual %b",
                         current_test, resp_valid);
                tb_errors++;
            end
        end
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        if (!timed_out) begin
            @(negedge clock);
            req_valid = 1'b0;
            while ((loads_pending != 0 || miss_pending || !req_ready) && waited < WAIT_LIMIT) begin
                @(negedge clock);
                waited++;
            end
            if (loads_pending != 0 || miss_pending || !req_ready) begin
                $display("%s: the cache did not go idle within %0d cycles",
                         current_test, WAIT_LIMIT);
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic start_test(input string name);
        current_test = name;
        u_checker.current_test = name;
        errors_before = tb_errors + checker_errors;
    endtask

    task automatic finish_test();
        int new_errors;
        wait_idle();
        new_errors = tb_errors + checker_errors - errors_before;
        tests_run++;
        if (timed_out) begin
            tests_failed++;
            $display("test %s: did not finish", current_test);
        end else if (new_errors != 0) begin
            tests_failed++;
            $display("test %s: failed with %0d errors", current_test, new_errors);
        end else begin
            $display("test %s: passed", current_test);
        end
    endtask

    initial begin
        dcache_pkg::addr_t     addr;
        dcache_pkg::mem_size_e size;
        void'($urandom(89659));
        reset        = 1'b1;
        req_valid    = 1'b0;
        req_addr     = '0;
        req_data     = '0;
        req_size     = dcache_pkg::BYTE;
        req_is_store = 1'b0;
        for (int a = 0; a < 512; a++) begin
            mem_blocks[a / 8][8 * (a % 8) +: 8] = (8'(a) + 8'h5A) ^ ((a >= 256) ? 8'h80 : 8'h00);
        end
        repeat (8) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        start_test("cold_loads");
        issue(16'h0005, '0, dcache_pkg::BYTE, 1'b0);
        issue(16'h001E, '0, dcache_pkg::HALF, 1'b0);
        issue(16'h0024, '0, dcache_pkg::WORD, 1'b0);
        issue(16'h01F7, '0, dcache_pkg::BYTE, 1'b0);
        finish_test();

        start_test("hit_latency");
        issue(16'h0024, '0, dcache_pkg::WORD, 1'b0);
        check_hit_latency();
        issue(16'h0020, '0, dcache_pkg::BYTE, 1'b0);
        check_hit_latency();
        finish_test();

        start_test("store_hit_merge");
        issue(16'h0028, '0, dcache_pkg::WORD, 1'b0);
        issue(16'h0029, 32'h0000_00A5, dcache_pkg::BYTE, 1'b1);
        issue(16'h002E, 32'h0000_BEEF, dcache_pkg::HALF, 1'b1);
        issue(16'h0029, '0, dcache_pkg::BYTE, 1'b0);
        issue(16'h002E, '0, dcache_pkg::HALF, 1'b0);
        issue(16'h002C, '0, dcache_pkg::WORD, 1'b0);
        issue(16'h0028, 32'h1122_3344, dcache_pkg::WORD, 1'b1);
        issue(16'h002A, '0, dcache_pkg::HALF, 1'b0);
        issue(16'h0028, '0, dcache_pkg::WORD, 1'b0);
        finish_test();

        start_test("store_miss_allocate");
        issue(16'h00C4, 32'hCAFE_F00D, dcache_pkg::WORD, 1'b1);
        issue(16'h00C4, '0, dcache_pkg::WORD, 1'b0);
        issue(16'h00C6, '0, dcache_pkg::HALF, 1'b0);
        issue(16'h00C0, 32'h0000_0077, dcache_pkg::BYTE, 1'b1);
        issue(16'h00C0, '0, dcache_pkg::WORD, 1'b0);
        finish_test();

        // All four addresses share index 6
        start_test("index_conflict");
        issue(16'h0030, '0, dcache_pkg::WORD, 1'b0);
        issue(16'h00B0, '0, dcache_pkg::WORD, 1'b0);
        issue(16'h0130, '0, dcache_pkg::WORD, 1'b0);
        issue(16'h01B0, '0, dcache_pkg::WORD, 1'b0);
        issue(16'h0132, 32'h0000_55AA, dcache_pkg::HALF, 1'b1);
        issue(16'h0030, '0, dcache_pkg::WORD, 1'b0);
        issue(16'h0130, '0, dcache_pkg::WORD, 1'b0);
        issue(16'h01B4, '0, dcache_pkg::WORD, 1'b0);
        finish_test();

        start_test("random_mix");
        for (int i = 0; i < 300; i++) begin
            size = dcache_pkg::mem_size_e'($urandom_range(0, 2));
            addr = dcache_pkg::addr_t'($urandom_range(0, 511));
            if (size == dcache_pkg::HALF) begin
                addr[0] = 1'b0;
            end
            if (size == dcache_pkg::WORD) begin
                addr[1:0] = 2'b00;
            end
            issue(addr, $urandom(), size, $urandom_range(0, 9) < 4);
            if ($urandom_range(0, 3) == 0) begin
                idle_cycle();
            end
        end
        finish_test();

        $display("%0d tests run, %0d passed, %0d failed",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (timed_out || tests_failed != 0 || tb_errors + checker_errors != 0) begin
            $display("tests failed");
        end else begin
            $display("all tests passed");
        end
        $finish;
    end

endmodule
